//--- Bender.yml
package:
  name: csr_rw_unit

export_include_dirs:
  - .

sources:
  - csr_pkg.sv
  - csr_addr_decode.sv
  - csr_trap_regs.sv
  - csr_irq_regs.sv
  - csr_read_mux.sv
  - csr_rw_unit.sv
  - target: test
    files:
      - tb_csr_rw_unit.sv

//--- csr_addr_decode.sv
// CSR address decoder: maps the access address to a register select and write strobe
`timescale 1ns/1ns
`default_nettype none

`include "csr_params.svh"

module csr_addr_decode (
	input wire logic [`CSR_ADDR_W-1:0] rw_addr,
	input wire logic rw_valid,
	output csr_pkg::csr_sel_e sel,
	output logic wr
);

	import csr_pkg::*;

	always_comb
	begin
		case (rw_addr)
			`CSR_ADDR_MSTATUS: sel = CSR_SEL_MSTATUS;
			`CSR_ADDR_MISA: sel = CSR_SEL_MISA;
			`CSR_ADDR_MIE: sel = CSR_SEL_MIE;
			`CSR_ADDR_MTVEC: sel = CSR_SEL_MTVEC;
			`CSR_ADDR_MSCRATCH: sel = CSR_SEL_MSCRATCH;
			`CSR_ADDR_MEPC: sel = CSR_SEL_MEPC;
			`CSR_ADDR_MCAUSE: sel = CSR_SEL_MCAUSE;
			`CSR_ADDR_MTVAL: sel = CSR_SEL_MTVAL;
			`CSR_ADDR_MIP: sel = CSR_SEL_MIP;
			`CSR_ADDR_MVENDORID: sel = CSR_SEL_MVENDORID;
			`CSR_ADDR_MARCHID: sel = CSR_SEL_MARCHID;
			`CSR_ADDR_MIMPID: sel = CSR_SEL_MIMPID;
			`CSR_ADDR_MHARTID: sel = CSR_SEL_MHARTID;
			default: sel = CSR_SEL_NONE; // Reads as zero
		endcase
	end

	// Only writable registers get a strobe
	always_comb
	begin
		case (sel)
			CSR_SEL_MSTATUS,
			CSR_SEL_MIE,
			CSR_SEL_MTVEC,
			CSR_SEL_MSCRATCH,
			CSR_SEL_MEPC,
			CSR_SEL_MCAUSE,
			CSR_SEL_MTVAL: wr = rw_valid;
			default: wr = 1'b0; // misa, mip, ID registers, unmapped
		endcase
	end

endmodule

`default_nettype wire

//--- csr_irq_regs.sv
// Interrupt state registers: mie enable bits and registered mip pending bits
`timescale 1ns/1ns
`default_nettype none

`include "csr_params.svh"

module csr_irq_regs (
	input wire logic clk,
	input wire logic resetn,
	input csr_pkg::csr_sel_e sel,
	input wire logic wr,
	input csr_pkg::csr_upd_e rw_upd_type,
	input wire logic [`CSR_XLEN-1:0] rw_mask_v,
	input wire logic sw_irq,
	input wire logic tmr_irq,
	input wire logic ext_irq,
	output logic mie_msie,
	output logic mie_mtie,
	output logic mie_meie,
	output logic mip_msip,
	output logic mip_mtip,
	output logic mip_meip
);

	import csr_pkg::*;

	logic [`CSR_XLEN-1:0] mie_old;
	logic [`CSR_XLEN-1:0] mie_new;

	// Enable bits sit at 3, 7 and 11 of the operand
	always_comb
	begin
		mie_old = '0;
		mie_old[3] = mie_msie;
		mie_old[7] = mie_mtie;
		mie_old[11] = mie_meie;
		mie_new = csr_update(mie_old, rw_mask_v, rw_upd_type);
	end

	always_ff @(posedge clk or negedge resetn)
	begin
		if (!resetn)
		begin
			mie_msie <= 1'b0;
			mie_mtie <= 1'b0;
			mie_meie <= 1'b0;
		end
		else if (wr && (sel == CSR_SEL_MIE))
		begin
			mie_msie <= mie_new[3];
			mie_mtie <= mie_new[7];
			mie_meie <= mie_new[11];
		end
	end

	// Requests held by the source until cleared there
	always_ff @(posedge clk or negedge resetn)
	begin
		if (!resetn)
		begin
			mip_msip <= 1'b0;
			mip_mtip <= 1'b0;
			mip_meip <= 1'b0;
		end
		else
		begin
			mip_msip <= sw_irq;
			mip_mtip <= tmr_irq;
			mip_meip <= ext_irq;
		end
	end

endmodule

`default_nettype wire

//--- csr_params.svh
// CSR unit parameters: data widths, machine CSR addresses, reset and identity values
`ifndef CSR_PARAMS_SVH
`define CSR_PARAMS_SVH

`define CSR_XLEN 32
`define CSR_ADDR_W 12
`define CSR_CAUSE_W 8

`define CSR_ADDR_MSTATUS 12'h300
`define CSR_ADDR_MISA 12'h301
`define CSR_ADDR_MIE 12'h304
`define CSR_ADDR_MTVEC 12'h305
`define CSR_ADDR_MSCRATCH 12'h340
`define CSR_ADDR_MEPC 12'h341
`define CSR_ADDR_MCAUSE 12'h342
`define CSR_ADDR_MTVAL 12'h343
`define CSR_ADDR_MIP 12'h344
`define CSR_ADDR_MVENDORID 12'hF11
`define CSR_ADDR_MARCHID 12'hF12
`define CSR_ADDR_MIMPID 12'hF13
`define CSR_ADDR_MHARTID 12'hF14

`define CSR_MTVEC_BASE_INIT 30'd0 // BASE field only, MODE resets to direct
`define CSR_MCAUSE_INIT 32'd16 // Interrupt bit clear
`define CSR_MISA_VAL 32'h4000_0110 // RV32 with I and E flags
`define CSR_MVENDORID_VAL 32'h0000_0000
`define CSR_MARCHID_VAL 32'h0000_0000
`define CSR_MIMPID_VAL 32'h312E_3030
`define CSR_MHARTID_VAL 32'h0000_0000

`endif

//--- csr_pkg.sv
// CSR unit package: register select and update opcode types, shared update rule
`default_nettype none

`include "csr_params.svh"

package csr_pkg;

	typedef enum logic [1:0] {
		CSR_UPD_LOAD = 2'd0,
		CSR_UPD_SET = 2'd1,
		CSR_UPD_CLR = 2'd2
	} csr_upd_e;

	typedef enum logic [3:0] {
		CSR_SEL_NONE, CSR_SEL_MSTATUS, CSR_SEL_MISA, CSR_SEL_MIE,
		CSR_SEL_MTVEC, CSR_SEL_MSCRATCH, CSR_SEL_MEPC, CSR_SEL_MCAUSE,
		CSR_SEL_MTVAL, CSR_SEL_MIP, CSR_SEL_MVENDORID, CSR_SEL_MARCHID,
		CSR_SEL_MIMPID, CSR_SEL_MHARTID
	} csr_sel_e;

	// Clear keeps only the bits the operand has set; code 3 yields zero
	function automatic logic [`CSR_XLEN-1:0] csr_update(
		input logic [`CSR_XLEN-1:0] old_v,
		input logic [`CSR_XLEN-1:0] mask_v,
		input csr_upd_e upd_type
	);
		logic [`CSR_XLEN-1:0] new_v;
		case (upd_type)
			CSR_UPD_LOAD: new_v = mask_v;
			CSR_UPD_SET: new_v = old_v | mask_v;
			CSR_UPD_CLR: new_v = old_v & mask_v;
			default: new_v = '0;
		endcase
		return new_v;
	endfunction

endpackage

`default_nettype wire

//--- csr_read_mux.sv
// CSR read multiplexer: builds each register's read layout and returns the selected old value
`timescale 1ns/1ns
`default_nettype none

`include "csr_params.svh"

module csr_read_mux (
	input csr_pkg::csr_sel_e sel,
	input wire logic mstatus_mie,
	input wire logic mstatus_mpie,
	input wire logic [`CSR_XLEN-1:0] mtvec_q,
	input wire logic [`CSR_XLEN-1:0] mepc_q,
	input wire logic [`CSR_XLEN-1:0] mcause_q,
	input wire logic [`CSR_XLEN-1:0] mtval_q,
	input wire logic [`CSR_XLEN-1:0] mscratch_q,
	input wire logic mie_msie,
	input wire logic mie_mtie,
	input wire logic mie_meie,
	input wire logic mip_msip,
	input wire logic mip_mtip,
	input wire logic mip_meip,
	output logic [`CSR_XLEN-1:0] rw_dout
);

	import csr_pkg::*;

	logic [`CSR_XLEN-1:0] mstatus_word;
	logic [`CSR_XLEN-1:0] mie_word;
	logic [`CSR_XLEN-1:0] mip_word;

	// MPP fixed at machine mode
	assign mstatus_word = {19'd0, 2'b11, 3'd0, mstatus_mpie, 3'd0, mstatus_mie, 3'd0};
	assign mie_word = {20'd0, mie_meie, 3'd0, mie_mtie, 3'd0, mie_msie, 3'd0};
	assign mip_word = {20'd0, mip_meip, 3'd0, mip_mtip, 3'd0, mip_msip, 3'd0};

	always_comb
	begin
		case (sel)
			CSR_SEL_MSTATUS: rw_dout = mstatus_word;
			CSR_SEL_MISA: rw_dout = `CSR_MISA_VAL;
			CSR_SEL_MIE: rw_dout = mie_word;
			CSR_SEL_MTVEC: rw_dout = mtvec_q;
			CSR_SEL_MSCRATCH: rw_dout = mscratch_q;
			CSR_SEL_MEPC: rw_dout = mepc_q;
			CSR_SEL_MCAUSE: rw_dout = mcause_q; // Interrupt flag in bit 31
			CSR_SEL_MTVAL: rw_dout = mtval_q;
			CSR_SEL_MIP: rw_dout = mip_word;
			CSR_SEL_MVENDORID: rw_dout = `CSR_MVENDORID_VAL;
			CSR_SEL_MARCHID: rw_dout = `CSR_MARCHID_VAL;
			CSR_SEL_MIMPID: rw_dout = `CSR_MIMPID_VAL;
			CSR_SEL_MHARTID: rw_dout = `CSR_MHARTID_VAL;
			default: rw_dout = '0;
		endcase
	end

endmodule

`default_nettype wire

//--- csr_rw_unit.sv
// Machine-mode CSR read/write unit: decode, trap and interrupt registers, read mux
`timescale 1ns/1ns
`default_nettype none

`include "csr_params.svh"

module csr_rw_unit (
	input wire logic clk,
	input wire logic resetn,
	input wire logic [`CSR_ADDR_W-1:0] rw_addr,
	input csr_pkg::csr_upd_e rw_upd_type,
	input wire logic [`CSR_XLEN-1:0] rw_mask_v,
	input wire logic rw_valid,
	output logic [`CSR_XLEN-1:0] rw_dout,
	input wire logic trap_enter,
	input wire logic trap_is_intr,
	input wire logic [`CSR_CAUSE_W-1:0] trap_cause,
	input wire logic [`CSR_XLEN-1:0] trap_ret_addr,
	input wire logic [`CSR_XLEN-1:0] trap_val,
	output logic [`CSR_XLEN-1:0] trap_vec_addr,
	input wire logic trap_ret,
	output logic [`CSR_XLEN-1:0] mepc_ret_addr,
	input wire logic sw_irq,
	input wire logic tmr_irq,
	input wire logic ext_irq,
	output logic mstatus_mie,
	output logic mie_msie,
	output logic mie_mtie,
	output logic mie_meie
);

	import csr_pkg::*;

	csr_sel_e sel;
	logic wr;
	logic mstatus_mpie;
	logic [`CSR_XLEN-1:0] mtvec_q;
	logic [`CSR_XLEN-1:0] mcause_q;
	logic [`CSR_XLEN-1:0] mtval_q;
	logic [`CSR_XLEN-1:0] mscratch_q;
	logic mip_msip;
	logic mip_mtip;
	logic mip_meip;

	csr_addr_decode u_addr_decode (
		.rw_addr(rw_addr),
		.rw_valid(rw_valid),
		.sel(sel),
		.wr(wr)
	);

	csr_trap_regs u_trap_regs (
		.clk(clk),
		.resetn(resetn),
		.sel(sel),
		.wr(wr),
		.rw_upd_type(rw_upd_type),
		.rw_mask_v(rw_mask_v),
		.trap_enter(trap_enter),
		.trap_ret(trap_ret),
		.trap_is_intr(trap_is_intr),
		.trap_cause(trap_cause),
		.trap_ret_addr(trap_ret_addr),
		.trap_val(trap_val),
		.mstatus_mie(mstatus_mie),
		.mstatus_mpie(mstatus_mpie),
		.mtvec_q(mtvec_q),
		.mepc_q(mepc_ret_addr), // mepc doubles as the return address
		.mcause_q(mcause_q),
		.mtval_q(mtval_q),
		.mscratch_q(mscratch_q),
		.trap_vec_addr(trap_vec_addr)
	);

	csr_irq_regs u_irq_regs (
		.clk(clk),
		.resetn(resetn),
		.sel(sel),
		.wr(wr),
		.rw_upd_type(rw_upd_type),
		.rw_mask_v(rw_mask_v),
		.sw_irq(sw_irq),
		.tmr_irq(tmr_irq),
		.ext_irq(ext_irq),
		.mie_msie(mie_msie),
		.mie_mtie(mie_mtie),
		.mie_meie(mie_meie),
		.mip_msip(mip_msip),
		.mip_mtip(mip_mtip),
		.mip_meip(mip_meip)
	);

	csr_read_mux u_read_mux (
		.sel(sel),
		.mstatus_mie(mstatus_mie),
		.mstatus_mpie(mstatus_mpie),
		.mtvec_q(mtvec_q),
		.mepc_q(mepc_ret_addr),
		.mcause_q(mcause_q),
		.mtval_q(mtval_q),
		.mscratch_q(mscratch_q),
		.mie_msie(mie_msie),
		.mie_mtie(mie_mtie),
		.mie_meie(mie_meie),
		.mip_msip(mip_msip),
		.mip_mtip(mip_mtip),
		.mip_meip(mip_meip),
		.rw_dout(rw_dout)
	);

endmodule

`default_nettype wire

//--- csr_trap_regs.sv
// Trap state registers: mstatus, mtvec, mepc, mcause, mtval, mscratch and vector address
`timescale 1ns/1ns
`default_nettype none

`include "csr_params.svh"

module csr_trap_regs (
	input wire logic clk,
	input wire logic resetn,
	input csr_pkg::csr_sel_e sel,
	input wire logic wr,
	input csr_pkg::csr_upd_e rw_upd_type,
	input wire logic [`CSR_XLEN-1:0] rw_mask_v,
	input wire logic trap_enter,
	input wire logic trap_ret,
	input wire logic trap_is_intr,
	input wire logic [`CSR_CAUSE_W-1:0] trap_cause,
	input wire logic [`CSR_XLEN-1:0] trap_ret_addr,
	input wire logic [`CSR_XLEN-1:0] trap_val,
	output logic mstatus_mie,
	output logic mstatus_mpie,
	output logic [`CSR_XLEN-1:0] mtvec_q,
	output logic [`CSR_XLEN-1:0] mepc_q,
	output logic [`CSR_XLEN-1:0] mcause_q,
	output logic [`CSR_XLEN-1:0] mtval_q,
	output logic [`CSR_XLEN-1:0] mscratch_q,
	output logic [`CSR_XLEN-1:0] trap_vec_addr
);

	import csr_pkg::*;

	logic [`CSR_XLEN-1:0] mstatus_old;
	logic [`CSR_XLEN-1:0] mstatus_new;
	logic [`CSR_XLEN-1:0] vec_offset;

	always_comb
	begin
		mstatus_old = '0;
		mstatus_old[3] = mstatus_mie;
		mstatus_old[7] = mstatus_mpie;
		mstatus_new = csr_update(mstatus_old, rw_mask_v, rw_upd_type);
	end

	// Trap entry beats trap return, both beat a CSR write
	always_ff @(posedge clk or negedge resetn)
	begin
		if (!resetn)
		begin
			mstatus_mie <= 1'b0;
			mstatus_mpie <= 1'b1;
		end
		else if (trap_enter)
		begin
			mstatus_mie <= 1'b0;
			mstatus_mpie <= mstatus_mie; // Save enable
		end
		else if (trap_ret)
		begin
			mstatus_mie <= mstatus_mpie;
			mstatus_mpie <= 1'b1;
		end
		else if (wr && (sel == CSR_SEL_MSTATUS))
		begin
			mstatus_mie <= mstatus_new[3];
			mstatus_mpie <= mstatus_new[7];
		end
	end

	always_ff @(posedge clk or negedge resetn)
	begin
		if (!resetn)
			mtvec_q <= {`CSR_MTVEC_BASE_INIT, 2'b00};
		else if (wr && (sel == CSR_SEL_MTVEC))
			mtvec_q <= csr_update(mtvec_q, rw_mask_v, rw_upd_type);
	end

	always_ff @(posedge clk or negedge resetn)
	begin
		if (!resetn)
			mcause_q <= `CSR_MCAUSE_INIT;
		else if (trap_enter)
			mcause_q <= {trap_is_intr, {(`CSR_XLEN-1-`CSR_CAUSE_W){1'b0}}, trap_cause};
		else if (wr && (sel == CSR_SEL_MCAUSE))
			mcause_q <= csr_update(mcause_q, rw_mask_v, rw_upd_type);
	end

	always_ff @(posedge clk)
	begin
		if (trap_enter)
		begin
			mepc_q <= trap_ret_addr;
			mtval_q <= trap_val;
		end
		else
		begin
			if (wr && (sel == CSR_SEL_MEPC))
				mepc_q <= csr_update(mepc_q, rw_mask_v, rw_upd_type);
			if (wr && (sel == CSR_SEL_MTVAL))
				mtval_q <= csr_update(mtval_q, rw_mask_v, rw_upd_type);
		end
	end

	always_ff @(posedge clk)
	begin
		if (wr && (sel == CSR_SEL_MSCRATCH))
			mscratch_q <= csr_update(mscratch_q, rw_mask_v, rw_upd_type);
	end

	// Vectored mode only offsets interrupts
	assign vec_offset = ((mtvec_q[1:0] == 2'd1) && trap_is_intr) ?
		{{(`CSR_XLEN-`CSR_CAUSE_W-2){1'b0}}, trap_cause, 2'b00} : '0;
	assign trap_vec_addr = {mtvec_q[`CSR_XLEN-1:2], 2'b00} + vec_offset;

endmodule

`default_nettype wire

//--- files.f
+incdir+.
csr_pkg.sv
csr_addr_decode.sv
csr_trap_regs.sv
csr_irq_regs.sv
csr_read_mux.sv
csr_rw_unit.sv
tb_csr_rw_unit.sv

//--- tb_csr_rw_unit.sv
// Self-checking testbench for the CSR read/write unit with register model, trap and irq checks
`timescale 1ns/1ns
`default_nettype none

`include "csr_params.svh"

module tb_csr_rw_unit;

	import csr_pkg::*;

	localparam int WAIT_LIMIT = 8; // Cycles before a wait gives up

	logic clk;
	logic resetn;
	logic [`CSR_ADDR_W-1:0] rw_addr;
	csr_upd_e rw_upd_type;
	logic [`CSR_XLEN-1:0] rw_mask_v;
	logic rw_valid;
	logic [`CSR_XLEN-1:0] rw_dout;
	logic trap_enter;
	logic trap_is_intr;
	logic [`CSR_CAUSE_W-1:0] trap_cause;
	logic [`CSR_XLEN-1:0] trap_ret_addr;
	logic [`CSR_XLEN-1:0] trap_val;
	logic [`CSR_XLEN-1:0] trap_vec_addr;
	logic trap_ret;
	logic [`CSR_XLEN-1:0] mepc_ret_addr;
	logic sw_irq;
	logic tmr_irq;
	logic ext_irq;
	logic mstatus_mie;
	logic mie_msie;
	logic mie_mtie;
	logic mie_meie;

	integer seed = 27483;
	int errors = 0;
	int checks = 0;
	logic [`CSR_XLEN-1:0] exp_scratch = 'x; // No reset on these three
	logic [`CSR_XLEN-1:0] exp_mepc = 'x;
	logic [`CSR_XLEN-1:0] exp_mtval = 'x;
	logic [`CSR_XLEN-1:0] exp_mie = '0;

	csr_rw_unit u_csr_rw_unit (.*);

	initial
	begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// Entry clears MIE on the next edge
	assert property (@(posedge clk) disable iff (!resetn) trap_enter |=> !mstatus_mie)
	else
	begin
		errors++;
		$display("[ERROR] %0t ns: MIE still set after trap entry", $time);
	end

	assert property (@(posedge clk) disable iff (!resetn)
		trap_enter |=> (mepc_ret_addr == $past(trap_ret_addr)))
	else
	begin
		errors++;
		$display("[ERROR] %0t ns: mepc_ret_addr did not take the entry address", $time);
	end

	// Enable bits only move on a mie write
	assert property (@(posedge clk) disable iff (!resetn)
		!(rw_valid && (rw_addr == `CSR_ADDR_MIE)) |=> $stable({mie_meie, mie_mtie, mie_msie}))
	else
	begin
		errors++;
		$display("[ERROR] %0t ns: mie enable bits changed without a mie write", $time);
	end

	function automatic logic [31:0] predict_word(input logic [31:0] old_w,
		input logic [31:0] opnd, input logic [1:0] op);
		if (op == 2'd0)
			return opnd;
		else if (op == 2'd1)
			return old_w | opnd;
		else if (op == 2'd2)
			return old_w & opnd; // Clear keeps the operand's set bits
		return 32'd0;
	endfunction

	task automatic check_word(input string what, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		assert (got === exp)
		else
		begin
			errors++;
			$display("[ERROR] %0t ns: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic csr_read(input logic [11:0] addr, input logic [31:0] exp, input string what);
		@(posedge clk);
		rw_addr <= addr;
		rw_valid <= 1'b0;
		@(negedge clk);
		check_word(what, rw_dout, exp);
	endtask

	// Old value is checked mid-cycle and the write lands on the next edge
	task automatic csr_access(input logic [11:0] addr, input csr_upd_e op,
		input logic [31:0] opnd, input logic [31:0] exp_old, input string what);
		@(posedge clk);
		rw_addr <= addr;
		rw_upd_type <= op;
		rw_mask_v <= opnd;
		rw_valid <= 1'b1;
		@(negedge clk);
		if (!$isunknown(exp_old))
			check_word(what, rw_dout, exp_old);
		@(posedge clk);
		rw_valid <= 1'b0;
	endtask

	task automatic random_rw(input logic [11:0] addr, input string what,
		inout logic [31:0] model);
		logic [31:0] opnd;
		logic [1:0] op_code;
		for (int i = 0; i < 8; i++)
		begin
			opnd = $random(seed);
			op_code = (i == 0) ? 2'd0 : 2'({$random(seed)} % 3); // Load first
			csr_access(addr, csr_upd_e'(op_code), opnd, model, what);
			model = predict_word(model, opnd, op_code);
		end
		csr_read(addr, model, what);
	endtask

	task automatic enter_trap(input logic intr, input logic [7:0] cause,
		input logic [31:0] ret_addr, input logic [31:0] tval);
		@(posedge clk);
		trap_enter <= 1'b1;
		trap_is_intr <= intr;
		trap_cause <= cause;
		trap_ret_addr <= ret_addr;
		trap_val <= tval;
		@(posedge clk);
		trap_enter <= 1'b0;
	endtask

	task automatic check_vector(input logic intr, input logic [7:0] cause, input logic [31:0] exp);
		@(posedge clk);
		trap_is_intr <= intr;
		trap_cause <= cause;
		@(negedge clk);
		check_word("trap_vec_addr", trap_vec_addr, exp);
	endtask

	// Expects rw_addr on mip and a request driven at the last edge
	task automatic wait_mip(input logic [31:0] exp);
		int n;
		n = 0;
		@(negedge clk);
		while ((rw_dout !== exp) && (n < WAIT_LIMIT))
		begin
			@(negedge clk);
			n++;
		end
		if (rw_dout !== exp)
		begin
			errors++;
			$display("Timed out waiting for mip to show the interrupt request");
		end
		else
			check_word("mip latency", n, 1);
	endtask

	initial
	begin
		logic [31:0] opnd;
		logic [31:0] base;
		logic [7:0] cause;
		logic [1:0] op_code;
		resetn = 1'b0;
		rw_addr = '0;
		rw_upd_type = CSR_UPD_LOAD;
		rw_mask_v = '0;
		rw_valid = 1'b0;
		trap_enter = 1'b0;
		trap_is_intr = 1'b0;
		trap_cause = '0;
		trap_ret_addr = '0;
		trap_val = '0;
		trap_ret = 1'b0;
		sw_irq = 1'b0;
		tmr_irq = 1'b0;
		ext_irq = 1'b0;
		for (int i = 0; i < 16; i++)
			@(posedge clk);
		resetn <= 1'b1;

		csr_read(`CSR_ADDR_MSTATUS, 32'h0000_1880, "mstatus"); // MPP = 3, MPIE = 1
		csr_read(`CSR_ADDR_MIE, 32'd0, "mie");
		csr_read(`CSR_ADDR_MTVEC, 32'd0, "mtvec");
		csr_read(`CSR_ADDR_MIP, 32'd0, "mip");
		csr_read(`CSR_ADDR_MCAUSE, 32'd16, "mcause");
		csr_read(`CSR_ADDR_MISA, 32'h4000_0110, "misa");
		csr_read(`CSR_ADDR_MIMPID, 32'h312E_3030, "mimpid");
		csr_read(12'h7C0, 32'd0, "unmapped CSR");
		check_word("enable outputs", {mstatus_mie, mie_msie, mie_mtie, mie_meie}, 4'd0);

		random_rw(`CSR_ADDR_MSCRATCH, "mscratch", exp_scratch);
		random_rw(`CSR_ADDR_MEPC, "mepc", exp_mepc);
		random_rw(`CSR_ADDR_MTVAL, "mtval", exp_mtval);

		for (int i = 0; i < 8; i++)
		begin
			opnd = $random(seed);
			op_code = 2'({$random(seed)} % 3);
			csr_access(`CSR_ADDR_MIE, csr_upd_e'(op_code), opnd, exp_mie, "mie");
			exp_mie = predict_word(exp_mie, opnd, op_code) & 32'h0000_0888;
			@(negedge clk);
			check_word("mie outputs", {mie_meie, mie_mtie, mie_msie},
				{exp_mie[11], exp_mie[7], exp_mie[3]});
		end
		csr_access(`CSR_ADDR_MIP, CSR_UPD_LOAD, 32'hFFFF_FFFF, 32'd0, "mip");
		csr_read(`CSR_ADDR_MIP, 32'd0, "mip after write");
		csr_access(`CSR_ADDR_MIMPID, CSR_UPD_LOAD, 32'd0, 32'h312E_3030, "mimpid");
		csr_read(`CSR_ADDR_MIMPID, 32'h312E_3030, "mimpid after write");
		csr_access(`CSR_ADDR_MHARTID, CSR_UPD_SET, 32'hFFFF_FFFF, 32'd0, "mhartid");
		csr_read(`CSR_ADDR_MHARTID, 32'd0, "mhartid after write");

		csr_access(`CSR_ADDR_MSTATUS, CSR_UPD_SET, 32'h8, 32'h0000_1880, "mstatus");
		@(negedge clk);
		check_word("mstatus_mie", mstatus_mie, 1'b1);
		exp_mepc = $random(seed);
		exp_mtval = $random(seed);
		cause = $random(seed);
		enter_trap(1'b0, cause, exp_mepc, exp_mtval);
		@(negedge clk);
		check_word("mepc_ret_addr", mepc_ret_addr, exp_mepc);
		check_word("mstatus_mie", mstatus_mie, 1'b0);
		csr_read(`CSR_ADDR_MEPC, exp_mepc, "mepc after entry");
		csr_read(`CSR_ADDR_MCAUSE, {24'd0, cause}, "mcause after entry");
		csr_read(`CSR_ADDR_MTVAL, exp_mtval, "mtval after entry");
		csr_read(`CSR_ADDR_MSTATUS, 32'h0000_1880, "mstatus after entry"); // MPIE holds old MIE
		@(posedge clk);
		trap_ret <= 1'b1;
		@(posedge clk);
		trap_ret <= 1'b0;
		@(negedge clk);
		check_word("mstatus_mie after return", mstatus_mie, 1'b1);
		csr_read(`CSR_ADDR_MSTATUS, 32'h0000_1888, "mstatus after return");
		enter_trap(1'b1, 8'd11, 32'h0000_0400, 32'd0);
		csr_read(`CSR_ADDR_MCAUSE, 32'h8000_000B, "mcause after interrupt entry");

		base = {$random(seed)} & 32'hFFFF_FFFC;
		csr_access(`CSR_ADDR_MTVEC, CSR_UPD_LOAD, base | 32'd1, 32'd0, "mtvec");
		for (int i = 0; i < 4; i++)
		begin
			cause = $random(seed);
			check_vector(1'b1, cause, base + ({24'd0, cause} << 2));
			check_vector(1'b0, cause, base);
		end
		csr_access(`CSR_ADDR_MTVEC, CSR_UPD_CLR, 32'hFFFF_FFFC, base | 32'd1, "mtvec");
		cause = $random(seed);
		check_vector(1'b1, cause, base); // Direct mode ignores the cause

		csr_read(`CSR_ADDR_MIP, 32'd0, "mip idle");
		@(posedge clk);
		sw_irq <= 1'b1;
		wait_mip(32'h0000_0008);
		@(posedge clk);
		tmr_irq <= 1'b1;
		wait_mip(32'h0000_0088);
		@(posedge clk);
		ext_irq <= 1'b1;
		wait_mip(32'h0000_0888);

		@(posedge clk);
		$display("Checks run: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	end

endmodule

`default_nettype wire
